//--- src/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int IMEM_WORDS = 256;  // ROM depth in words
    localparam int DMEM_WORDS = 256;  // RAM depth in words
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    // Major opcodes, RV32I base encoding
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Loads and stores, halfwords not supported
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SW  = 3'b010;

    // OP and OP-IMM function
    localparam logic [2:0] F3_ADD  = 3'b000;  // Also SUB
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // SRL or SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    typedef logic [3:0] alu_op_t;
    localparam alu_op_t ALU_ADD   = 4'd0;
    localparam alu_op_t ALU_SUB   = 4'd1;
    localparam alu_op_t ALU_SLL   = 4'd2;
    localparam alu_op_t ALU_SLT   = 4'd3;
    localparam alu_op_t ALU_SLTU  = 4'd4;
    localparam alu_op_t ALU_XOR   = 4'd5;
    localparam alu_op_t ALU_SRL   = 4'd6;
    localparam alu_op_t ALU_SRA   = 4'd7;
    localparam alu_op_t ALU_OR    = 4'd8;
    localparam alu_op_t ALU_AND   = 4'd9;
    localparam alu_op_t ALU_PASSB = 4'd10;  // LUI

    typedef logic [1:0] wb_sel_t;
    localparam wb_sel_t WB_ALU = 2'd0;
    localparam wb_sel_t WB_MEM = 2'd1;
    localparam wb_sel_t WB_PC4 = 2'd2;  // Link address

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word, six ways to read it
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

endpackage

`default_nettype wire

//--- src/rv_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module rv_fetch (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    trigger_i,
    input  logic                    take_branch_i,
    input  logic [rv_pkg::XLEN-1:0] pc_target_i,
    output logic [rv_pkg::XLEN-1:0] pc_o,
    output rv_pkg::instr_u          instr_o,
    output logic                    run_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] rom [IMEM_WORDS];  // Program image
    logic [XLEN-1:0] pc_next;

    initial begin
        $readmemh("program.hex", rom);
    end

    // Trigger latch, sticky until reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run_o <= 1'b0;
        end else if (trigger_i) begin
            run_o <= 1'b1;
        end
    end

    assign pc_next = take_branch_i ? pc_target_i : pc_o + XLEN'(4);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_o <= '0;
        end else if (run_o) begin  // Frozen while idle
            pc_o <= pc_next;
        end
    end

    assign instr_o = rom[pc_o[IMEM_AW+1:2]];  // Word index

    // Targets from execute keep the PC on a word boundary
    a_pc_aligned : assert property (@(posedge clk) disable iff (rst) pc_o[1:0] == 2'b00)
        else $error("PC not word aligned: %h", pc_o);

endmodule

`default_nettype wire

//--- src/rv_decode.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decode (
    input  rv_pkg::instr_u          instr_i,
    input  logic                    run_i,
    output logic                    reg_wr_en_o,
    output logic                    mem_wr_en_o,
    output logic                    mem_byte_o,
    output logic                    load_unsigned_o,
    output rv_pkg::wb_sel_t         wb_sel_o,
    output rv_pkg::alu_op_t         alu_op_o,
    output logic                    alu_src_a_pc_o,
    output logic                    alu_src_a_zero_o,
    output logic                    alu_src_b_imm_o,
    output logic                    is_branch_o,
    output logic                    is_jal_o,
    output logic                    is_jalr_o,
    output logic [rv_pkg::XLEN-1:0] imm_o,
    output logic [4:0]              rs1_addr_o,
    output logic [4:0]              rs2_addr_o,
    output logic [4:0]              rd_addr_o
);
    import rv_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            alt;             // SUB or SRA variant
    logic            reg_wr, mem_wr;  // Before run masking
    alu_op_t         arith_op;
    logic [XLEN-1:0] imm_i_t, imm_s_t, imm_b_t, imm_u_t, imm_j_t;

    assign opcode     = instr_i.r.opcode;
    assign funct3     = instr_i.r.funct3;
    assign rs1_addr_o = instr_i.r.rs1;
    assign rs2_addr_o = instr_i.r.rs2;
    assign rd_addr_o  = instr_i.r.rd;

    // Immediates, sign bit is always instr[31]
    assign imm_i_t = {{20{instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
    assign imm_s_t = {{20{instr_i.s.imm_11_5[6]}}, instr_i.s.imm_11_5, instr_i.s.imm_4_0};
    assign imm_b_t = {{19{instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
                      instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
    assign imm_u_t = {instr_i.u.imm_31_12, 12'h000};  // Already shifted
    assign imm_j_t = {{11{instr_i.j.imm_20}}, instr_i.j.imm_20, instr_i.j.imm_19_12,
                      instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};

    // funct7[5] means SUB only for OP, SRA for both
    assign alt = instr_i.r.funct7[5] && (opcode == OPC_OP || funct3 == F3_SR);

    always_comb begin
        case (funct3)
            F3_ADD:  arith_op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  arith_op = ALU_SLL;
            F3_SLT:  arith_op = ALU_SLT;
            F3_SLTU: arith_op = ALU_SLTU;
            F3_XOR:  arith_op = ALU_XOR;
            F3_SR:   arith_op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   arith_op = ALU_OR;
            F3_AND:  arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        reg_wr           = 1'b0;
        mem_wr           = 1'b0;
        mem_byte_o       = 1'b0;
        load_unsigned_o  = 1'b0;
        wb_sel_o         = WB_ALU;
        alu_op_o         = ALU_ADD;  // Address and AUIPC sum
        alu_src_a_pc_o   = 1'b0;
        alu_src_a_zero_o = 1'b0;
        alu_src_b_imm_o  = 1'b0;
        is_branch_o      = 1'b0;
        is_jal_o         = 1'b0;
        is_jalr_o        = 1'b0;
        imm_o            = imm_i_t;
        case (opcode)
            OPC_LUI: begin
                reg_wr           = 1'b1;
                alu_src_a_zero_o = 1'b1;
                alu_src_b_imm_o  = 1'b1;
                alu_op_o         = ALU_PASSB;
                imm_o            = imm_u_t;
            end
            OPC_AUIPC: begin
                reg_wr          = 1'b1;
                alu_src_a_pc_o  = 1'b1;
                alu_src_b_imm_o = 1'b1;
                imm_o           = imm_u_t;
            end
            OPC_JAL: begin
                reg_wr   = 1'b1;
                is_jal_o = 1'b1;
                wb_sel_o = WB_PC4;
                imm_o    = imm_j_t;
            end
            OPC_JALR: begin
                reg_wr    = 1'b1;
                is_jalr_o = 1'b1;
                wb_sel_o  = WB_PC4;
            end
            OPC_BRANCH: begin
                is_branch_o = 1'b1;  // Condition resolved in execute
                imm_o       = imm_b_t;
            end
            OPC_LOAD: begin
                alu_src_b_imm_o = 1'b1;
                wb_sel_o        = WB_MEM;
                case (funct3)
                    F3_LB: begin
                        reg_wr     = 1'b1;
                        mem_byte_o = 1'b1;
                    end
                    F3_LW:   reg_wr = 1'b1;
                    F3_LBU: begin
                        reg_wr          = 1'b1;
                        mem_byte_o      = 1'b1;
                        load_unsigned_o = 1'b1;
                    end
                    default: ;  // Halfword loads dropped
                endcase
            end
            OPC_STORE: begin
                alu_src_b_imm_o = 1'b1;
                imm_o           = imm_s_t;
                case (funct3)
                    F3_SB: begin
                        mem_wr     = 1'b1;
                        mem_byte_o = 1'b1;
                    end
                    F3_SW:   mem_wr = 1'b1;
                    default: ;
                endcase
            end
            OPC_OPIMM: begin
                reg_wr          = 1'b1;
                alu_src_b_imm_o = 1'b1;
                alu_op_o        = arith_op;
            end
            OPC_OP: begin
                reg_wr   = 1'b1;
                alu_op_o = arith_op;
            end
            default: ;  // Unknown opcode retires as NOP
        endcase
    end

    // Nothing commits before trigger
    assign reg_wr_en_o = reg_wr && run_i;
    assign mem_wr_en_o = mem_wr && run_i;

endmodule

`default_nettype wire

//--- src/rv_execute.sv
`timescale 1ns/10ps
`default_nettype none

module rv_execute (
    input  logic [rv_pkg::XLEN-1:0] pc_i,
    input  logic [rv_pkg::XLEN-1:0] rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0] rs2_data_i,
    input  logic [rv_pkg::XLEN-1:0] imm_i,
    input  rv_pkg::alu_op_t         alu_op_i,
    input  logic [2:0]              funct3_i,
    input  logic                    alu_src_a_pc_i,
    input  logic                    alu_src_a_zero_i,
    input  logic                    alu_src_b_imm_i,
    input  logic                    is_branch_i,
    input  logic                    is_jal_i,
    input  logic                    is_jalr_i,
    output logic [rv_pkg::XLEN-1:0] alu_result_o,
    output logic [rv_pkg::XLEN-1:0] pc_target_o,
    output logic                    take_branch_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] op_a, op_b;
    logic [4:0]      shamt;
    logic            cond;             // Branch condition holds
    logic [XLEN-1:0] base, target_sum;

    // Zero beats PC for LUI
    assign op_a  = alu_src_a_zero_i ? '0 : (alu_src_a_pc_i ? pc_i : rs1_data_i);
    assign op_b  = alu_src_b_imm_i ? imm_i : rs2_data_i;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:   alu_result_o = op_a + op_b;
            ALU_SUB:   alu_result_o = op_a - op_b;
            ALU_SLL:   alu_result_o = op_a << shamt;
            ALU_SLT:   alu_result_o = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:  alu_result_o = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:   alu_result_o = op_a ^ op_b;
            ALU_SRL:   alu_result_o = op_a >> shamt;
            ALU_SRA:   alu_result_o = $signed(op_a) >>> shamt;  // Sign fill
            ALU_OR:    alu_result_o = op_a | op_b;
            ALU_AND:   alu_result_o = op_a & op_b;
            ALU_PASSB: alu_result_o = op_b;
            default:   alu_result_o = op_a + op_b;
        endcase
    end

    // Compare always on the two register operands
    always_comb begin
        case (funct3_i)
            F3_BEQ:  cond = rs1_data_i == rs2_data_i;
            F3_BNE:  cond = rs1_data_i != rs2_data_i;
            F3_BLT:  cond = $signed(rs1_data_i) < $signed(rs2_data_i);
            F3_BGE:  cond = $signed(rs1_data_i) >= $signed(rs2_data_i);
            F3_BLTU: cond = rs1_data_i < rs2_data_i;
            F3_BGEU: cond = rs1_data_i >= rs2_data_i;
            default: cond = 1'b0;  // Reserved encodings never taken
        endcase
    end

    assign base        = is_jalr_i ? rs1_data_i : pc_i;
    assign target_sum  = base + imm_i;
    assign pc_target_o = {target_sum[XLEN-1:1], target_sum[0] & ~is_jalr_i};  // JALR clears bit 0

    assign take_branch_o = is_jal_i || is_jalr_i || (is_branch_i && cond);

endmodule

`default_nettype wire

//--- src/rv_result.sv
`timescale 1ns/10ps
`default_nettype none

module rv_result (
    input  logic                    clk,
    input  logic [rv_pkg::XLEN-1:0] addr_i,
    input  logic [rv_pkg::XLEN-1:0] store_data_i,
    input  logic [rv_pkg::XLEN-1:0] pc_i,
    input  logic                    mem_wr_en_i,
    input  logic                    mem_byte_i,
    input  logic                    load_unsigned_i,
    input  rv_pkg::wb_sel_t         wb_sel_i,
    output logic [rv_pkg::XLEN-1:0] wb_data_o
);
    import rv_pkg::*;

    logic [XLEN-1:0]    ram [DMEM_WORDS];
    logic [DMEM_AW-1:0] word_addr;
    logic [1:0]         lane;        // Byte within word
    logic [3:0]         byte_en;
    logic [XLEN-1:0]    wr_word, rd_word, load_data;
    logic [7:0]         rd_byte;

    assign word_addr = addr_i[DMEM_AW+1:2];
    assign lane      = addr_i[1:0];
    assign byte_en   = mem_byte_i ? (4'b0001 << lane) : 4'b1111;
    assign wr_word   = mem_byte_i ? {4{store_data_i[7:0]}} : store_data_i;  // Byte on every lane

    always_ff @(posedge clk) begin
        if (mem_wr_en_i) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    ram[word_addr][8*b +: 8] <= wr_word[8*b +: 8];  // Other lanes kept
                end
            end
        end
    end

    // Asynchronous read
    assign rd_word   = ram[word_addr];
    assign rd_byte   = rd_word[{lane, 3'b000} +: 8];
    assign load_data = mem_byte_i ? {{24{rd_byte[7] & ~load_unsigned_i}}, rd_byte} : rd_word;

    always_comb begin
        case (wb_sel_i)
            WB_MEM:  wb_data_o = load_data;
            WB_PC4:  wb_data_o = pc_i + XLEN'(4);  // Return address
            default: wb_data_o = addr_i;           // ALU result
        endcase
    end

    // Address from execute must suit a word store
    a_sw_aligned : assert property (@(posedge clk) mem_wr_en_i && !mem_byte_i |-> lane == 2'b00)
        else $error("Misaligned SW to %h", addr_i);

endmodule

`default_nettype wire

//--- src/rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [4:0]              rs1_addr_i,
    input  logic [4:0]              rs2_addr_i,
    input  logic [4:0]              rd_addr_i,
    input  logic                    wr_en_i,
    input  logic [rv_pkg::XLEN-1:0] wr_data_i,
    output logic [rv_pkg::XLEN-1:0] rs1_data_o,
    output logic [rv_pkg::XLEN-1:0] rs2_data_o,
    output logic [rv_pkg::XLEN-1:0] a0_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_en_i && rd_addr_i != 5'd0) begin  // x0 stays zero
            regs[rd_addr_i] <= wr_data_i;
        end
    end

    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];
    assign a0_o       = regs[10];  // x10

endmodule

`default_nettype wire

//--- src/rv_core_top.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    trigger_i,
    output logic [rv_pkg::XLEN-1:0] pc_o,
    output logic [rv_pkg::XLEN-1:0] a0_o
);
    import rv_pkg::*;

    instr_u          instr;
    logic            run;
    logic            take_branch;
    logic [XLEN-1:0] pc_target;
    // Decode to the rest
    logic            reg_wr_en, mem_wr_en, mem_byte, load_unsigned;
    wb_sel_t         wb_sel;
    alu_op_t         alu_op;
    logic            alu_src_a_pc, alu_src_a_zero, alu_src_b_imm;
    logic            is_branch, is_jal, is_jalr;
    logic [XLEN-1:0] imm;
    logic [4:0]      rs1_addr, rs2_addr, rd_addr;
    // Datapath
    logic [XLEN-1:0] rs1_data, rs2_data, alu_result, wb_data;

    rv_fetch i_fetch (
        .clk           (clk),
        .rst           (rst),
        .trigger_i     (trigger_i),
        .take_branch_i (take_branch),
        .pc_target_i   (pc_target),
        .pc_o          (pc_o),
        .instr_o       (instr),
        .run_o         (run)
    );

    rv_decode i_decode (
        .instr_i          (instr),
        .run_i            (run),
        .reg_wr_en_o      (reg_wr_en),
        .mem_wr_en_o      (mem_wr_en),
        .mem_byte_o       (mem_byte),
        .load_unsigned_o  (load_unsigned),
        .wb_sel_o         (wb_sel),
        .alu_op_o         (alu_op),
        .alu_src_a_pc_o   (alu_src_a_pc),
        .alu_src_a_zero_o (alu_src_a_zero),
        .alu_src_b_imm_o  (alu_src_b_imm),
        .is_branch_o      (is_branch),
        .is_jal_o         (is_jal),
        .is_jalr_o        (is_jalr),
        .imm_o            (imm),
        .rs1_addr_o       (rs1_addr),
        .rs2_addr_o       (rs2_addr),
        .rd_addr_o        (rd_addr)
    );

    rv_regfile i_regfile (
        .clk        (clk),
        .rst        (rst),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rd_addr_i  (rd_addr),
        .wr_en_i    (reg_wr_en),
        .wr_data_i  (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .a0_o       (a0_o)
    );

    rv_execute i_execute (
        .pc_i             (pc_o),
        .rs1_data_i       (rs1_data),
        .rs2_data_i       (rs2_data),
        .imm_i            (imm),
        .alu_op_i         (alu_op),
        .funct3_i         (instr.r.funct3),  // Branch condition select
        .alu_src_a_pc_i   (alu_src_a_pc),
        .alu_src_a_zero_i (alu_src_a_zero),
        .alu_src_b_imm_i  (alu_src_b_imm),
        .is_branch_i      (is_branch),
        .is_jal_i         (is_jal),
        .is_jalr_i        (is_jalr),
        .alu_result_o     (alu_result),
        .pc_target_o      (pc_target),
        .take_branch_o    (take_branch)
    );

    rv_result i_result (
        .clk             (clk),
        .addr_i          (alu_result),
        .store_data_i    (rs2_data),
        .pc_i            (pc_o),
        .mem_wr_en_i     (mem_wr_en),
        .mem_byte_i      (mem_byte),
        .load_unsigned_i (load_unsigned),
        .wb_sel_i        (wb_sel),
        .wb_data_o       (wb_data)
    );

endmodule

`default_nettype wire

//--- verification/tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;
    import rv_pkg::*;

    localparam int IDLE_LIMIT  = 20;   // Reset release to trigger
    localparam int START_LIMIT = 10;   // Trigger to first retire
    localparam int RUN_LIMIT   = 300;  // Whole program with margin
    localparam int HOLD_CYCLES = 4;    // Self-loop repeats before the end counts

    logic            clk     = 1'b0;
    logic            rst     = 1'b1;
    logic            trigger = 1'b0;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] a0;

    // ISA model state
    logic [XLEN-1:0] prog       [IMEM_WORDS];  // Own copy of the image
    logic [XLEN-1:0] model_ram  [DMEM_WORDS];
    logic [XLEN-1:0] model_regs [32];
    logic [XLEN-1:0] model_pc;

    rv_core_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .trigger_i (trigger),
        .pc_o      (pc),
        .a0_o      (a0)
    );

    always #5 clk = ~clk;  // 10 ns period

    function automatic string op_name(input logic [6:0] opcode);
        case (opcode)
            OPC_LUI:    return "LUI";
            OPC_AUIPC:  return "AUIPC";
            OPC_JAL:    return "JAL";
            OPC_JALR:   return "JALR";
            OPC_BRANCH: return "BRANCH";
            OPC_LOAD:   return "LOAD";
            OPC_STORE:  return "STORE";
            OPC_OPIMM:  return "OP-IMM";
            OPC_OP:     return "OP";
            default:    return "NOP";  // Unknown opcode
        endcase
    endfunction

    function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                                input logic [XLEN-1:0] a, b);
        case (f3)
            F3_ADD:  return alt ? a - b : a + b;
            F3_SLL:  return a << b[4:0];
            F3_SLT:  return XLEN'($signed(a) < $signed(b));
            F3_SLTU: return XLEN'(a < b);
            F3_XOR:  return a ^ b;
            F3_SR: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];  // Sign fill
                end else begin
                    return a >> b[4:0];
                end
            end
            F3_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [XLEN-1:0] a, b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            F3_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Executes one instruction on the model state
    function automatic void rv_step(input instr_u ins);
        logic [XLEN-1:0] a, b, imm, val, addr, word, next_pc;
        logic [7:0]      byte_v;
        logic            wr;
        a       = model_regs[ins.r.rs1];
        b       = model_regs[ins.r.rs2];
        imm     = {{20{ins.i.imm_11_0[11]}}, ins.i.imm_11_0};  // I-type by default
        next_pc = model_pc + 32'd4;
        val     = '0;
        wr      = 1'b0;
        case (ins.r.opcode)
            OPC_LUI: begin
                val = {ins.u.imm_31_12, 12'h000};
                wr  = 1'b1;
            end
            OPC_AUIPC: begin
                val = model_pc + {ins.u.imm_31_12, 12'h000};
                wr  = 1'b1;
            end
            OPC_JAL: begin
                imm     = {{12{ins.j.imm_20}}, ins.j.imm_19_12, ins.j.imm_11,
                           ins.j.imm_10_1, 1'b0};
                val     = model_pc + 32'd4;  // Link
                next_pc = model_pc + imm;
                wr      = 1'b1;
            end
            OPC_JALR: begin
                val     = model_pc + 32'd4;
                next_pc = (a + imm) & ~32'd1;  // Odd sum rounds down
                wr      = 1'b1;
            end
            OPC_BRANCH: begin
                imm = {{20{ins.b.imm_12}}, ins.b.imm_11, ins.b.imm_10_5, ins.b.imm_4_1, 1'b0};
                if (branch_taken(ins.r.funct3, a, b)) begin
                    next_pc = model_pc + imm;
                end
            end
            OPC_LOAD: begin
                addr   = a + imm;
                word   = model_ram[addr[DMEM_AW+1:2]];
                byte_v = 8'(word >> {addr[1:0], 3'b000});
                wr     = 1'b1;
                case (ins.r.funct3)
                    F3_LW:   val = word;
                    F3_LB:   val = {{24{byte_v[7]}}, byte_v};
                    F3_LBU:  val = {24'h000000, byte_v};
                    default: wr = 1'b0;  // Halfword, no write
                endcase
            end
            OPC_STORE: begin
                imm  = {{20{ins.s.imm_11_5[6]}}, ins.s.imm_11_5, ins.s.imm_4_0};
                addr = a + imm;
                if (ins.r.funct3 == F3_SW) begin
                    model_ram[addr[DMEM_AW+1:2]] = b;
                end else if (ins.r.funct3 == F3_SB) begin
                    model_ram[addr[DMEM_AW+1:2]][{addr[1:0], 3'b000} +: 8] = b[7:0];
                end
            end
            OPC_OPIMM: begin
                // Only SRAI has a variant, flagged by imm[10]
                val = alu_ref(ins.r.funct3, ins.r.funct3 == F3_SR && ins.i.imm_11_0[10],
                              a, imm);
                wr  = 1'b1;
            end
            OPC_OP: begin
                val = alu_ref(ins.r.funct3, ins.r.funct7[5], a, b);  // SUB and SRA
                wr  = 1'b1;
            end
            default: ;
        endcase
        if (wr && ins.r.rd != 5'd0) begin
            model_regs[ins.r.rd] = val;
        end
        model_pc = next_pc;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_pc(input string name, input logic [XLEN-1:0] expected,
                            input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_a0(input string name, input logic [XLEN-1:0] expected,
                            input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    initial begin : drive_inputs
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);
        trigger <= 1'b1;  // One-cycle pulse
        @(posedge clk);
        trigger <= 1'b0;
    end

    // Sampling on the falling edge, away from DUT updates
    initial begin : compare_run
        instr_u          ins;
        string           tag;
        int              waited;
        int              stable;
        int              steps;
        logic [XLEN-1:0] prev_pc;
        model_pc = '0;
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = '0;
        end
        for (int k = 0; k < DMEM_WORDS; k++) begin
            model_ram[k] = '0;
        end
        $readmemh("verification/program.hex", prog);
        waited = 0;
        while (rst !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > 10) abort_run("Timeout: reset was never released");
        end
        waited = 0;
        while (trigger !== 1'b1) begin  // Core must sit still
            check_pc("idle pc", '0, pc);
            check_a0("idle a0", '0, a0);
            @(negedge clk);
            waited++;
            if (waited > IDLE_LIMIT) abort_run("Timeout: trigger was never raised");
        end
        waited = 0;
        while (pc == '0) begin
            check_a0("a0 before first retire", '0, a0);
            @(negedge clk);
            waited++;
            if (waited > START_LIMIT) abort_run("Timeout: PC never left 0 after the trigger");
        end
        stable = 0;
        steps  = 0;
        while (stable < HOLD_CYCLES && steps < RUN_LIMIT) begin
            ins     = prog[model_pc[IMEM_AW+1:2]];
            tag     = $sformatf("%s at %h", op_name(ins.r.opcode), model_pc);
            prev_pc = model_pc;
            rv_step(ins);
            check_pc($sformatf("%s pc", tag), model_pc, pc);
            check_a0($sformatf("%s a0", tag), model_regs[10], a0);
            stable = (model_pc == prev_pc) ? stable + 1 : 0;  // Self-loop count
            steps++;
            @(negedge clk);
        end
        if (stable >= HOLD_CYCLES) begin
            check_pc("final self-loop pc", model_pc, pc);
            check_a0("final x10", model_regs[10], a0);
            $display("STATUS: PASS");
            $finish;
        end else begin
            abort_run("Timeout: program did not reach its final self-loop");
        end
    end

endmodule

`default_nettype wire

//--- verification/program.hex
// Instruction words in address order, five per row, hex
// Row n starts at byte address 20*n
FF900293 00300313 00628533 40628533 00631533 // x5=-7 x6=3, add sub sll
0062A533 0062B533 0062C533 0062D533 4062D533 // slt sltu xor srl sra
0062E533 0062F533 00429513 0042D513 4042D513 // or and slli srli srai
FFF2A513 FFF33513 0F02C513 70036513 7F02F513 // slti sltiu xori ori andi
ABCDE537 12345517 00628463 00630463 00150513 // lui auipc, beq not taken then taken
00631463 00629463 00150513 00534463 0062C463 // bne pair, blt pair
00150513 0062D463 00535463 00150513 0062E463 // bge pair, bltu not taken
00536463 00150513 00537463 0062F463 00150513 // bltu taken, bgeu pair
008000EF 00150513 00008513 0B000393 011380E7 // jal link to a0, jalr with odd sum
00150513 00150513 00150513 00008513 876545B7 // skipped, jalr link to a0, lui
32158593 00B02823 01002503 F8000613 00C008A3 // sw then lw, sb lane 1
01002503 01100503 01104503 00C00823 01000503 // lw lb lbu lane 1, sb lb lane 0
00C00923 01204503 006009A3 01300503 00000000 // lane 2 and 3, unknown opcode
01002503 0000006F                            // final lw, jal to itself

//--- sources.f
src/rv_pkg.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_regfile.sv
src/rv_core_top.sv
verification/tb_rv_core.sv

//--- Makefile
TOP := tb_rv_core
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)

# The instruction ROM loads its image from the working directory
run: build
	cp verification/program.hex program.hex
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module rv_core_top

clean:
	rm -rf obj_dir $(LOG) program.hex
